// ==== hw/mul_pkg.sv ====
package mul_pkg;

   // operand and result widths
   localparam int OPERAND_W = 48;
   localparam int PRODUCT_W = 2 * OPERAND_W;
   localparam int WORD_W = 32;
   localparam int WORDS_PER_PRODUCT = 3;

   // array rows handled by pipeline stage 1
   localparam int SPLIT_ROW = 24;

   // product buffer and the credits that reserve its slots
   localparam int FIFO_DEPTH = 4;
   localparam int CREDIT_W = 3;

   typedef logic [OPERAND_W-1:0] operand_t;
   typedef logic [PRODUCT_W-1:0] product_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [CREDIT_W-1:0] credit_t;

   // output word sequencing
   typedef enum logic [1:0] {SER_IDLE, SER_WORD0, SER_WORD1, SER_WORD2} ser_state_t;

endpackage

// ==== hw/operand_issue.sv ====
`timescale 1ns/100ps

module operand_issue import mul_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     op_valid,
   input  operand_t op_a,
   input  operand_t op_b,
   input  logic     fifo_pop,
   output logic     busy,
   output logic     issue_valid,
   output operand_t issue_a,
   output operand_t issue_b
);

   credit_t credit;
   logic    accept;

   // no free slot left downstream
   assign busy = (credit == '0);

   // strobes seen while busy are dropped
   assign accept = op_valid && !busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= accept;
      end
   end

   // operand registers, loaded only on an accepted strobe
   always_ff @(posedge clk) begin
      if (accept) begin
         issue_a <= op_a;
         issue_b <= op_b;
      end
   end

   // one credit per FIFO slot, returned when the serializer pops
   always_ff @(posedge clk) begin
      if (reset) begin
         credit <= credit_t'(FIFO_DEPTH);
      end else if (accept && !fifo_pop) begin
         credit <= credit - 1'b1;
      end else if (!accept && fifo_pop) begin
         credit <= credit + 1'b1;
      end
   end

   // a pop without a matching issue would push the count past the depth
   a_credit_max: assert property (@(posedge clk) disable iff (reset)
      credit <= credit_t'(FIFO_DEPTH));

   // an empty count must not wrap around
   a_credit_no_wrap: assert property (@(posedge clk) disable iff (reset)
      (credit == '0) |=> (credit <= credit_t'(1)));

endmodule

// ==== hw/array_multiplier.sv ====
`timescale 1ns/100ps

module array_multiplier import mul_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     issue_valid,
   input  operand_t issue_a,
   input  operand_t issue_b,
   output logic     prod_valid,
   output product_t prod_data
);

   // stage 1 results
   operand_t                          s1_sum_d;
   operand_t                          s1_carry_d;
   logic [SPLIT_ROW-1:0]              s1_low_d;
   logic                              s1_valid;
   operand_t                          s1_sum;
   operand_t                          s1_carry;
   logic [SPLIT_ROW-1:0]              s1_low;
   logic [OPERAND_W-SPLIT_ROW-1:0]    s1_a_hi;
   operand_t                          s1_b;

   // stage 2 result
   product_t prod_d;

   // one carry-save row: shifted sum + partial product + carries
   // result is {carry, sum}
   function automatic logic [2*OPERAND_W-1:0] csa_row(
      input operand_t sum_in,
      input operand_t carry_in,
      input operand_t pp
   );
      operand_t shifted;
      operand_t sum_out;
      operand_t carry_out;
      shifted = sum_in >> 1;
      sum_out = shifted ^ pp ^ carry_in;
      carry_out = (shifted & pp) | (shifted & carry_in) | (pp & carry_in);
      return {carry_out, sum_out};
   endfunction

   // rows 0 .. SPLIT_ROW-1
   always_comb begin
      operand_t sum_v;
      operand_t carry_v;
      operand_t pp;
      sum_v = '0;
      carry_v = '0;
      s1_low_d = '0;
      for (int i = 0; i < SPLIT_ROW; i++) begin
         pp = issue_a[i] ? issue_b : '0;
         {carry_v, sum_v} = csa_row(sum_v, carry_v, pp);
         // product bit i falls off the low end of the row
         s1_low_d[i] = sum_v[0];
      end
      s1_sum_d = sum_v;
      s1_carry_d = carry_v;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_valid) begin
         s1_sum <= s1_sum_d;
         s1_carry <= s1_carry_d;
         s1_low <= s1_low_d;
         s1_a_hi <= issue_a[OPERAND_W-1:SPLIT_ROW];
         s1_b <= issue_b;
      end
   end

   // rows SPLIT_ROW .. OPERAND_W-1, then the ripple row
   always_comb begin
      operand_t sum_v;
      operand_t carry_v;
      operand_t pp;
      logic     rc;
      prod_d = '0;
      prod_d[SPLIT_ROW-1:0] = s1_low;
      sum_v = s1_sum;
      carry_v = s1_carry;
      for (int i = SPLIT_ROW; i < OPERAND_W; i++) begin
         pp = s1_a_hi[i-SPLIT_ROW] ? s1_b : '0;
         {carry_v, sum_v} = csa_row(sum_v, carry_v, pp);
         prod_d[i] = sum_v[0];
      end

      // leftover carries line up with sum bit j+1
      rc = 1'b0;
      for (int j = 0; j < OPERAND_W-1; j++) begin
         prod_d[OPERAND_W+j] = carry_v[j] ^ sum_v[j+1] ^ rc;
         rc = (carry_v[j] & sum_v[j+1]) | (carry_v[j] & rc) | (sum_v[j+1] & rc);
      end
      // top bit, the final carry out is always zero for an unsigned product
      prod_d[PRODUCT_W-1] = carry_v[OPERAND_W-1] ^ rc;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         prod_valid <= 1'b0;
      end else begin
         prod_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_valid) begin
         prod_data <= prod_d;
      end
   end

endmodule

// ==== hw/product_fifo.sv ====
`timescale 1ns/100ps

module product_fifo import mul_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     prod_valid,
   input  product_t prod_data,
   input  logic     fifo_pop,
   output logic     fifo_empty,
   output product_t fifo_data
);

   product_t                      mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
   logic [CREDIT_W-1:0]           count;

   assign fifo_empty = (count == '0);

   // head entry, valid whenever not empty
   assign fifo_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (prod_valid) begin
         mem[wr_ptr] <= prod_data;
      end
   end

   // depth is a power of two so the pointers wrap by themselves
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (prod_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (fifo_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (prod_valid && !fifo_pop) begin
         count <= count + 1'b1;
      end else if (!prod_valid && fifo_pop) begin
         count <= count - 1'b1;
      end
   end

   // credits upstream must keep a slot free for every product in flight
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      !(prod_valid && count == CREDIT_W'(FIFO_DEPTH)));

   // serializer only pops with data present
   a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      fifo_pop |-> (count != '0));

endmodule

// ==== hw/word_serializer.sv ====
`timescale 1ns/100ps

module word_serializer import mul_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     fifo_empty,
   input  product_t fifo_data,
   output logic     fifo_pop,
   output word_t    res_word,
   output logic     res_valid,
   output logic     res_last
);

   ser_state_t state;
   ser_state_t state_next;
   product_t   hold;

   // next state and pop strobe
   always_comb begin
      fifo_pop = 1'b0;
      state_next = state;
      case (state)
         SER_IDLE: begin
            if (!fifo_empty) begin
               fifo_pop = 1'b1;
               state_next = SER_WORD0;
            end
         end
         SER_WORD0: state_next = SER_WORD1;
         SER_WORD1: state_next = SER_WORD2;
         SER_WORD2: begin
            // chain straight into the next product if one is waiting
            if (!fifo_empty) begin
               fifo_pop = 1'b1;
               state_next = SER_WORD0;
            end else begin
               state_next = SER_IDLE;
            end
         end
         default: state_next = SER_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= SER_IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         hold <= fifo_data;
      end
   end

   // low word first
   always_comb begin
      case (state)
         SER_WORD1: res_word = hold[WORD_W +: WORD_W];
         SER_WORD2: res_word = hold[2*WORD_W +: WORD_W];
         default:   res_word = hold[0 +: WORD_W];
      endcase
   end

   assign res_valid = (state != SER_IDLE);
   assign res_last = (state == SER_WORD2);

endmodule

// ==== hw/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit import mul_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     op_valid,
   input  operand_t op_a,
   input  operand_t op_b,
   output logic     busy,
   output word_t    res_word,
   output logic     res_valid,
   output logic     res_last
);

   // issue stage to multiplier
   logic     issue_valid;
   operand_t issue_a;
   operand_t issue_b;

   // multiplier to buffer
   logic     prod_valid;
   product_t prod_data;

   // buffer to serializer, pop also returns a credit
   logic     fifo_empty;
   product_t fifo_data;
   logic     fifo_pop;

   operand_issue operand_issue_i (
      .clk         (clk),
      .reset       (reset),
      .op_valid    (op_valid),
      .op_a        (op_a),
      .op_b        (op_b),
      .fifo_pop    (fifo_pop),
      .busy        (busy),
      .issue_valid (issue_valid),
      .issue_a     (issue_a),
      .issue_b     (issue_b)
   );

   array_multiplier array_multiplier_i (
      .clk         (clk),
      .reset       (reset),
      .issue_valid (issue_valid),
      .issue_a     (issue_a),
      .issue_b     (issue_b),
      .prod_valid  (prod_valid),
      .prod_data   (prod_data)
   );

   product_fifo product_fifo_i (
      .clk        (clk),
      .reset      (reset),
      .prod_valid (prod_valid),
      .prod_data  (prod_data),
      .fifo_pop   (fifo_pop),
      .fifo_empty (fifo_empty),
      .fifo_data  (fifo_data)
   );

   word_serializer word_serializer_i (
      .clk        (clk),
      .reset      (reset),
      .fifo_empty (fifo_empty),
      .fifo_data  (fifo_data),
      .fifo_pop   (fifo_pop),
      .res_word   (res_word),
      .res_valid  (res_valid),
      .res_last   (res_last)
   );

endmodule

// ==== dv/mul_unit_tb.sv ====
`timescale 1ns/100ps

module mul_unit_tb import mul_pkg::*; ();

   localparam int LATENCY = 5;
   localparam int BUSY_LIMIT = 50;
   localparam int DRAIN_LIMIT = 500;
   localparam int ISSUE_LIMIT = 400;

   logic     clk;
   logic     reset;
   logic     op_valid;
   operand_t op_a;
   operand_t op_b;
   logic     busy;
   word_t    res_word;
   logic     res_valid;
   logic     res_last;

   // scoreboard state, owned by the monitor
   product_t    expected_q [$];
   int          word_idx;
   int          credit_model;

   int unsigned cycle_count = 0;
   int unsigned issue_cycle;
   logic [31:0] seed;

   mul_unit mul_unit_i (
      .clk       (clk),
      .reset     (reset),
      .op_valid  (op_valid),
      .op_a      (op_a),
      .op_b      (op_b),
      .busy      (busy),
      .res_word  (res_word),
      .res_valid (res_valid),
      .res_last  (res_last)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   task automatic end_with_failure(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [PRODUCT_W-1:0] actual,
                          input logic [PRODUCT_W-1:0] expected);
      if (actual !== expected) begin
         end_with_failure($sformatf("mismatch %s: actual %h expected %h",
                                    name, actual, expected));
      end
   endtask

   // full-width unsigned product
   function automatic product_t operand_product(input operand_t a, input operand_t b);
      product_t wide_a;
      product_t wide_b;
      wide_a = product_t'(a);
      wide_b = product_t'(b);
      return wide_a * wide_b;
   endfunction

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // two draws per 48-bit operand
   task automatic next_operand(output operand_t v);
      logic [31:0] hi;
      seed = lcg_step(seed);
      hi = seed;
      seed = lcg_step(seed);
      v = {hi[15:0], seed};
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   // checks every output cycle against the expected queue and the credit model
   always @(negedge clk) begin
      product_t head;
      if (reset) begin
         expected_q.delete();
         word_idx = 0;
         credit_model = FIFO_DEPTH;
      end else begin
         if (res_valid) begin
            if (word_idx == 0) begin
               if (expected_q.size() == 0) begin
                  end_with_failure("a result word came out with no product pending");
               end
               // first word means the product has left the FIFO
               credit_model++;
            end
            head = expected_q[0];
            compare("res_word", res_word, head[word_idx*WORD_W +: WORD_W]);
            compare("res_last", res_last, word_idx == WORDS_PER_PRODUCT-1);
            if (word_idx == WORDS_PER_PRODUCT-1) begin
               void'(expected_q.pop_front());
               word_idx = 0;
            end else begin
               word_idx++;
            end
         end else begin
            if (word_idx != 0) begin
               end_with_failure("result words stopped before the last word of a product");
            end
            compare("res_last", res_last, 1'b0);
         end
         compare("busy", busy, credit_model == 0);
         if (op_valid && !busy) begin
            expected_q.push_back(operand_product(op_a, op_b));
            credit_model--;
         end
      end
   end

   task automatic wait_not_busy();
      int waited;
      waited = 0;
      while (busy) begin
         next_cycle();
         waited++;
         if (waited > BUSY_LIMIT) begin
            end_with_failure("timeout waiting for busy to go low");
         end
      end
   endtask

   task automatic send_pair(input operand_t a, input operand_t b);
      wait_not_busy();
      op_a = a;
      op_b = b;
      op_valid = 1'b1;
      issue_cycle = cycle_count;
      next_cycle();
      op_valid = 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (expected_q.size() != 0 || res_valid) begin
         next_cycle();
         waited++;
         if (waited > DRAIN_LIMIT) begin
            end_with_failure("timeout waiting for the pending products to come out");
         end
      end
   endtask

   // strobe on each cycle where busy is low
   task automatic issue_when_free(input int n);
      operand_t a;
      operand_t b;
      int       sent;
      int       waited;
      sent = 0;
      waited = 0;
      while (sent < n) begin
         if (!busy) begin
            next_operand(a);
            next_operand(b);
            op_a = a;
            op_b = b;
            op_valid = 1'b1;
            sent++;
         end else begin
            op_valid = 1'b0;
         end
         next_cycle();
         waited++;
         if (waited > ISSUE_LIMIT) begin
            end_with_failure("timeout while issuing operands, busy stayed high");
         end
      end
      op_valid = 1'b0;
   endtask

   task automatic single_products();
      operand_t x;
      operand_t a_list [4];
      operand_t b_list [4];
      int       waited;
      next_operand(x);
      a_list[0] = '0;
      b_list[0] = x;
      a_list[1] = operand_t'(1);
      b_list[1] = x;
      a_list[2] = '1;
      b_list[2] = '1;
      a_list[3] = 48'haaaa_aaaa_aaaa;
      b_list[3] = 48'h0020_0000_0000;
      for (int i = 0; i < 4; i++) begin
         send_pair(a_list[i], b_list[i]);
         waited = 0;
         while (!res_valid) begin
            next_cycle();
            waited++;
            if (waited > BUSY_LIMIT) begin
               end_with_failure("timeout waiting for the first result word");
            end
         end
         compare("first word latency", cycle_count - issue_cycle, LATENCY);
         drain();
      end
   endtask

   task automatic random_stream();
      issue_when_free(40);
      drain();
   endtask

   task automatic busy_credits();
      operand_t a;
      operand_t b;
      // four back to back from an empty unit use up every slot
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         next_operand(a);
         next_operand(b);
         op_a = a;
         op_b = b;
         op_valid = 1'b1;
         next_cycle();
      end
      op_valid = 1'b0;
      compare("busy after four issues", busy, 1'b1);
      issue_when_free(16);
      drain();
   endtask

   task automatic ignored_strobe();
      operand_t a;
      operand_t b;
      int       ignored;
      ignored = 0;
      // strobe every cycle, busy or not
      for (int i = 0; i < 30; i++) begin
         next_operand(a);
         next_operand(b);
         op_a = a;
         op_b = b;
         op_valid = 1'b1;
         if (busy) begin
            ignored++;
         end
         next_cycle();
      end
      op_valid = 1'b0;
      if (ignored == 0) begin
         end_with_failure("no strobe was given while busy was high");
      end
      drain();
   endtask

   task automatic reset_recovery();
      operand_t a;
      operand_t b;
      issue_when_free(6);
      reset = 1'b1;
      next_cycle();
      next_cycle();
      reset = 1'b0;
      // nothing left over from before the reset
      for (int i = 0; i < 10; i++) begin
         compare("busy", busy, 1'b0);
         compare("res_valid", res_valid, 1'b0);
         next_cycle();
      end
      next_operand(a);
      next_operand(b);
      send_pair(a, b);
      drain();
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      op_valid = 1'b0;
      op_a = '0;
      op_b = '0;
      seed = 32'h297485dd;
      repeat (5) @(posedge clk);
      #10;
      reset = 1'b0;

      single_products();
      random_stream();
      busy_credits();
      ignored_strobe();
      reset_recovery();

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== sources.f ====
hw/mul_pkg.sv
hw/operand_issue.sv
hw/array_multiplier.sv
hw/product_fifo.sv
hw/word_serializer.sv
hw/mul_unit.sv
dv/mul_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mul_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module mul_unit_tb \
   -f sources.f \
   -o mul_unit_sim

./obj_dir/mul_unit_sim
